//--- all.f
+incdir+verilog
verilog/rv_core_pkg.sv
verilog/rv_gpr.sv
verilog/rv_decoder.sv
verilog/rv_alu.sv
verilog/rv_control.sv
verilog/rv_core.sv
verification/rv_core_asserts.sv
verification/rv_core_tb.sv

//--- Makefile
TOP := rv_core_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timing --top-module $(TOP) -f all.f -o $(TOP)

run: build
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; fi

lint:
	verilator --lint-only -Wall --assert --timing --top-module rv_core -f all.f

clean:
	rm -rf obj_dir $(LOG)

//--- verification/rv_core_tb.sv
`include "rv_core_defs.svh"

module rv_core_tb;

	localparam int MEM_WORDS = 256;
	localparam int HALT_TIMEOUT = 2000; // Cycles allowed per program
	localparam int DATA_BASE = 'h200; // Data area from word 128 up
	localparam logic [31:0] EBREAK = 32'h0010_0073;

	logic clk = 1'b0;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r = '0;
	logic wb_ack = 1'b0;
	logic halted;

	logic [31:0] mem [MEM_WORDS]; // Memory seen by the bus
	logic [31:0] image [MEM_WORDS]; // Copied into mem while in reset
	integer seed = 32'h033164dd;
	int waits;
	logic active; // Wait count already chosen for the current cycle
	int wr_ptr; // Next program word

	rv_core DUT (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.halted(halted)
	);

	always #20 clk = ~clk;

	// Wishbone slave with 0 to 3 wait states per cycle
	always @(negedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < MEM_WORDS; i++) mem[i] = image[i];
			wb_ack <= 1'b0;
			active = 1'b0;
		end else if (wb_ack) begin
			wb_ack <= 1'b0; // Cycle ended at the last rising edge
			active = 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!active) begin
				active = 1'b1;
				waits = $random(seed) & 3;
			end
			if (waits == 0) begin
				if (wb_we)
					mem[wb_adr[9:2]] = wb_dat_w;
				else
					wb_dat_r <= mem[wb_adr[9:2]];
				wb_ack <= 1'b1;
			end else begin
				waits = waits - 1;
			end
		end
	end

	// Background pattern unique per word
	function automatic logic [31:0] fill_word(input int idx);
		return 32'h5a00_0000 | 32'(idx << 2);
	endfunction

	function automatic logic [31:0] lui_instr(input int rd, input int imm);
		return {imm[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic logic [31:0] addi_instr(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
	endfunction

	// f7 and f3 pairs are add 0/0, sub 32/0, and 0/7, or 0/6, xor 0/4, slt 0/2
	function automatic logic [31:0] rtype_instr(input int f7, input int f3, input int rd,
			input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] lw_instr(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
	endfunction

	function automatic logic [31:0] sw_instr(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	// f3 0 is BEQ, 1 is BNE
	function automatic logic [31:0] branch_instr(input int f3, input int rs1, input int rs2,
			input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jal_instr(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic stop_run();
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic start_program();
		for (int i = 0; i < MEM_WORDS; i++) image[i] = fill_word(i);
		wr_ptr = `RV_RESET_PC >> 2;
	endtask

	task automatic emit(input logic [31:0] w);
		image[wr_ptr] = w;
		wr_ptr++;
	endtask

	task automatic check_word(input logic [31:0] addr, input logic [31:0] exp);
		logic [31:0] got;
		got = mem[addr[9:2]];
		assert (got === exp) else begin
			$display("Fail at time %0t: mem[0x%03h] is %h, expected %h", $time, addr, got, exp);
			stop_run();
		end
	endtask

	// Reset for 16 cycles, then run until halted
	task automatic run_program();
		int cycles;
		@(negedge clk);
		rst_n = 1'b0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		assert (!halted) else begin
			$display("Fail at time %0t: halted is %b, expected 0", $time, halted);
			stop_run();
		end
		cycles = 0;
		while (!halted && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		assert (halted) else begin
			$display("Timeout: the core did not halt within %0d cycles", HALT_TIMEOUT);
			stop_run();
		end
	endtask

	task automatic test_arithmetic();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] u;
		logic [31:0] exp [11];
		a = -7;
		b = 100;
		u = 32'h12345 << 12;
		start_program();
		emit(addi_instr(1, 0, DATA_BASE));
		emit(lui_instr(2, 'h12345));
		emit(addi_instr(3, 0, -7));
		emit(addi_instr(4, 0, 100));
		emit(rtype_instr(0, 0, 5, 3, 4)); // add
		emit(rtype_instr(32, 0, 6, 3, 4)); // sub
		emit(rtype_instr(0, 7, 7, 3, 4)); // and
		emit(rtype_instr(0, 6, 8, 3, 4)); // or
		emit(rtype_instr(0, 4, 9, 3, 4)); // xor
		emit(rtype_instr(0, 2, 10, 3, 4)); // -7 < 100
		emit(rtype_instr(0, 2, 11, 4, 3)); // 100 < -7
		emit(addi_instr(12, 2, -1));
		for (int r = 2; r <= 12; r++) emit(sw_instr(r, 1, (r - 2) * 4));
		emit(EBREAK);
		run_program();
		exp[0] = u;
		exp[1] = a;
		exp[2] = b;
		exp[3] = a + b;
		exp[4] = a - b;
		exp[5] = a & b;
		exp[6] = a | b;
		exp[7] = a ^ b;
		exp[8] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		exp[9] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
		exp[10] = u - 1;
		for (int k = 0; k < 11; k++) check_word(DATA_BASE + 4 * k, exp[k]);
	endtask

	task automatic test_zero_reg();
		start_program();
		emit(addi_instr(1, 0, DATA_BASE));
		emit(addi_instr(0, 0, 55)); // Dropped since x0 stays zero
		emit(sw_instr(0, 1, 0));
		emit(addi_instr(2, 0, 77));
		emit(rtype_instr(0, 0, 3, 0, 2)); // x0 + x2
		emit(rtype_instr(0, 0, 4, 2, 0)); // x2 + x0
		emit(sw_instr(3, 1, 4));
		emit(sw_instr(4, 1, 8));
		emit(EBREAK);
		run_program();
		check_word(DATA_BASE, 32'd0);
		check_word(DATA_BASE + 4, 32'd77);
		check_word(DATA_BASE + 8, 32'd77);
	endtask

	task automatic test_load_store();
		logic [31:0] v1;
		logic [31:0] v2;
		v1 = -1234;
		v2 = (32'habcde << 12) + 32'h123;
		start_program();
		emit(addi_instr(1, 0, DATA_BASE));
		emit(addi_instr(2, 0, -1234));
		emit(lui_instr(3, 'habcde));
		emit(addi_instr(3, 3, 'h123));
		emit(addi_instr(9, 1, 'h100)); // Second base 0x300
		emit(sw_instr(2, 1, 'h40));
		emit(sw_instr(3, 1, 'h44));
		emit(sw_instr(3, 9, -4)); // Negative store offset
		emit(lw_instr(4, 1, 'h40));
		emit(addi_instr(6, 4, 1)); // Loaded value used at once
		emit(lw_instr(5, 1, 'h44));
		emit(rtype_instr(0, 0, 7, 4, 5)); // x5 read right after its load
		emit(lw_instr(8, 1, 'h80)); // Untouched preloaded word
		emit(sw_instr(4, 1, 0));
		emit(sw_instr(5, 1, 4));
		emit(sw_instr(6, 1, 8));
		emit(sw_instr(7, 1, 12));
		emit(sw_instr(8, 1, 16));
		emit(EBREAK);
		run_program();
		check_word(DATA_BASE + 'h40, v1);
		check_word(DATA_BASE + 'h44, v2);
		check_word(DATA_BASE + 'hfc, v2);
		check_word(DATA_BASE, v1);
		check_word(DATA_BASE + 4, v2);
		check_word(DATA_BASE + 8, v1 + 1);
		check_word(DATA_BASE + 12, v1 + v2);
		check_word(DATA_BASE + 16, fill_word((DATA_BASE + 'h80) >> 2));
	endtask

	task automatic test_branches();
		logic [31:0] link;
		link = `RV_RESET_PC + 13 * 4 + 4; // JAL sits at word 13
		start_program();
		emit(addi_instr(1, 0, DATA_BASE));
		emit(addi_instr(2, 0, 5));
		emit(addi_instr(3, 0, 5));
		emit(addi_instr(4, 0, 9));
		emit(addi_instr(5, 0, 'h111)); // Marker
		emit(branch_instr(0, 2, 3, 8)); // Taken BEQ
		emit(sw_instr(5, 1, 0));
		emit(branch_instr(1, 2, 4, 8)); // Taken BNE
		emit(sw_instr(5, 1, 4));
		emit(branch_instr(0, 2, 4, 8)); // Not taken
		emit(sw_instr(5, 1, 8));
		emit(branch_instr(1, 2, 3, 8)); // Not taken
		emit(sw_instr(5, 1, 12));
		emit(jal_instr(6, 8));
		emit(sw_instr(5, 1, 16));
		emit(sw_instr(6, 1, 20));
		emit(jal_instr(0, 12)); // Forward to the BNE below
		emit(sw_instr(5, 1, 24)); // Reached by the backward branch
		emit(EBREAK);
		emit(branch_instr(1, 2, 4, -8));
		run_program();
		check_word(DATA_BASE, fill_word(DATA_BASE >> 2));
		check_word(DATA_BASE + 4, fill_word((DATA_BASE + 4) >> 2));
		check_word(DATA_BASE + 8, 32'h111);
		check_word(DATA_BASE + 12, 32'h111);
		check_word(DATA_BASE + 16, fill_word((DATA_BASE + 16) >> 2));
		check_word(DATA_BASE + 20, link);
		check_word(DATA_BASE + 24, 32'h111);
	endtask

	task automatic test_halt();
		start_program();
		emit(addi_instr(1, 0, DATA_BASE));
		emit(addi_instr(2, 0, 42));
		emit(sw_instr(2, 1, 0));
		emit(EBREAK);
		emit(sw_instr(2, 1, 4)); // Never reached
		emit(sw_instr(2, 1, 8));
		run_program();
		check_word(DATA_BASE, 32'd42);
		check_word(DATA_BASE + 4, fill_word((DATA_BASE + 4) >> 2));
		check_word(DATA_BASE + 8, fill_word((DATA_BASE + 8) >> 2));

		// Undefined opcode halts as well
		start_program();
		emit(addi_instr(1, 0, DATA_BASE));
		emit(addi_instr(2, 0, 99));
		emit(sw_instr(2, 1, 12));
		emit(32'hffff_ffff);
		emit(sw_instr(2, 1, 16));
		run_program();
		check_word(DATA_BASE + 12, 32'd99);
		check_word(DATA_BASE + 16, fill_word((DATA_BASE + 16) >> 2));
	endtask

	initial begin
		rst_n = 1'b0;
		test_arithmetic();
		test_zero_reg();
		test_load_store();
		test_branches();
		test_halt();
		$display("Test passed");
		$finish;
	end

endmodule

//--- verification/rv_core_asserts.sv
module rv_core_asserts (
	input logic                 clk,
	input logic                 rst_n,
	input rv_core_pkg::wb_req_t bus,
	input logic                 wb_ack,
	input logic                 halted
);

	// Request held through wait states
	assert property (@(posedge clk) disable iff (!rst_n)
		(bus.stb && !wb_ack) |=> ($stable(bus.adr) && $stable(bus.we) && $stable(bus.dat_w)))
		else $error("Wishbone request changed while waiting for ack");

	assert property (@(posedge clk) disable iff (!rst_n) bus.stb |-> bus.cyc)
		else $error("Wishbone stb high without cyc");

	// No bus traffic once halted
	assert property (@(posedge clk) disable iff (!rst_n) halted |-> !bus.cyc)
		else $error("Bus cycle issued while halted");

	// First cycle out of reset is idle
	assert property (@(posedge clk) $rose(rst_n) |-> !bus.cyc)
		else $error("cyc high in the first cycle after reset");

endmodule

bind rv_core rv_core_asserts u_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.bus(bus),
	.wb_ack(wb_ack),
	.halted(halted)
);

//--- verilog/rv_core.sv
`include "rv_core_defs.svh"

module rv_core (
	input  logic                clk,
	input  logic                rst_n,
	output logic                wb_cyc,
	output logic                wb_stb,
	output logic                wb_we,
	output logic [`RV_XLEN-1:0] wb_adr,
	output logic [`RV_XLEN-1:0] wb_dat_w,
	input  logic [`RV_XLEN-1:0] wb_dat_r,
	input  logic                wb_ack,
	output logic                halted
);
	import rv_core_pkg::*;

	decoded_t dec;
	wb_req_t bus;
	logic [`RV_XLEN-1:0] instr;
	logic [`RV_XLEN-1:0] rdata1;
	logic [`RV_XLEN-1:0] rdata2;
	logic [`RV_XLEN-1:0] alu_b;
	logic [`RV_XLEN-1:0] alu_y;
	logic alu_eq;
	logic gpr_wen;
	logic [`RV_REG_AW-1:0] gpr_waddr;
	logic [`RV_XLEN-1:0] gpr_wdata;

	rv_control u_control (
		.clk(clk), .rst_n(rst_n), .dec(dec),
		.rdata2(rdata2), .alu_y(alu_y), .alu_eq(alu_eq),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.instr(instr), .alu_b(alu_b), .bus(bus),
		.gpr_wen(gpr_wen), .gpr_waddr(gpr_waddr), .gpr_wdata(gpr_wdata),
		.halted(halted)
	);

	rv_decoder u_decoder (.instr(instr), .dec(dec));

	// Operand a is always rs1
	rv_alu u_alu (.op(dec.alu_op), .a(rdata1), .b(alu_b), .y(alu_y), .eq(alu_eq));

	rv_gpr u_gpr (
		.clk(clk), .rst_n(rst_n), .ren(dec.ren), .wen(gpr_wen),
		.raddr1(dec.rs1), .raddr2(dec.rs2), .waddr(gpr_waddr),
		.wdata(gpr_wdata), .rdata1(rdata1), .rdata2(rdata2)
	);

	// Wishbone request broken out to pins
	assign wb_cyc = bus.cyc;
	assign wb_stb = bus.stb;
	assign wb_we = bus.we;
	assign wb_adr = bus.adr;
	assign wb_dat_w = bus.dat_w;

endmodule

//--- verilog/rv_control.sv
`include "rv_core_defs.svh"

module rv_control (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_core_pkg::decoded_t dec,
	input  logic [`RV_XLEN-1:0]   rdata2,
	input  logic [`RV_XLEN-1:0]   alu_y,
	input  logic                  alu_eq,
	input  logic [`RV_XLEN-1:0]   wb_dat_r,
	input  logic                  wb_ack,
	output logic [`RV_XLEN-1:0]   instr,
	output logic [`RV_XLEN-1:0]   alu_b,
	output rv_core_pkg::wb_req_t  bus,
	output logic                  gpr_wen,
	output logic [`RV_REG_AW-1:0] gpr_waddr,
	output logic [`RV_XLEN-1:0]   gpr_wdata,
	output logic                  halted
);
	import rv_core_pkg::*;

	ctrl_state_t state;
	logic [`RV_XLEN-1:0] pc;
	logic [`RV_XLEN-1:0] ir; // Instruction register
	logic [`RV_XLEN-1:0] mem_addr; // Load/store address held through MEM
	logic [`RV_XLEN-1:0] ld_data; // Load data waiting for WRITEBACK
	logic cyc_q; // Bus cycle in progress
	logic ack; // Ack of our own cycle
	logic [`RV_XLEN-1:0] pc_plus4;
	logic taken; // Branch or jump redirects the PC
	logic is_mem;

	assign ack = cyc_q & wb_ack;
	assign pc_plus4 = pc + `RV_ILEN_BYTES;
	assign is_mem = (dec.op == OP_LW) || (dec.op == OP_SW);
	assign taken = (dec.op == OP_JAL) ||
		(dec.op == OP_BEQ && alu_eq) ||
		(dec.op == OP_BNE && !alu_eq);

	// Register operand for R-type and compares, immediate otherwise
	assign alu_b = (dec.op == OP_ALU_R || dec.op == OP_BEQ || dec.op == OP_BNE) ?
		rdata2 : dec.imm;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_FETCH;
			pc <= `RV_RESET_PC;
			cyc_q <= 1'b0;
		end else begin
			case (state)
				ST_FETCH: begin
					if (!cyc_q) begin
						cyc_q <= 1'b1; // Open the fetch cycle at pc
					end else if (ack) begin
						cyc_q <= 1'b0;
						state <= ST_EXECUTE;
					end
				end
				ST_EXECUTE: begin
					if (dec.op == OP_HALT) begin
						state <= ST_HALTED; // PC stays at the halting instruction
					end else begin
						pc <= taken ? pc + dec.imm : pc_plus4;
						if (is_mem) begin
							cyc_q <= 1'b1; // Data cycle starts right away
							state <= ST_MEM;
						end else begin
							state <= ST_FETCH;
						end
					end
				end
				ST_MEM: begin
					if (ack) begin
						cyc_q <= 1'b0;
						state <= (dec.op == OP_LW) ? ST_WRITEBACK : ST_FETCH;
					end
				end
				ST_WRITEBACK: state <= ST_FETCH;
				default: state <= ST_HALTED; // Only reset leaves HALTED
			endcase
		end
	end

	// Data registers
	always_ff @(posedge clk) begin
		if (state == ST_FETCH && ack)
			ir <= wb_dat_r;
		if (state == ST_EXECUTE)
			mem_addr <= alu_y; // rs1 + imm
		if (state == ST_MEM && ack)
			ld_data <= wb_dat_r;
	end

	assign instr = ir;

	// Request fields stay stable for the whole cycle since ir and mem_addr do
	assign bus.cyc = cyc_q;
	assign bus.stb = cyc_q;
	assign bus.we = (state == ST_MEM) && (dec.op == OP_SW);
	assign bus.adr = (state == ST_MEM) ? mem_addr : pc;
	assign bus.dat_w = rdata2;

	// Loads write in WRITEBACK, everything else at the end of EXECUTE
	assign gpr_wen = dec.wen &&
		((state == ST_EXECUTE && dec.op != OP_LW) || state == ST_WRITEBACK);
	assign gpr_waddr = dec.rd;

	always_comb begin
		case (dec.op)
			OP_LUI: gpr_wdata = dec.imm;
			OP_JAL: gpr_wdata = pc_plus4; // Link address
			OP_LW:  gpr_wdata = ld_data;
			default: gpr_wdata = alu_y;
		endcase
	end

	assign halted = (state == ST_HALTED);

endmodule

//--- verilog/rv_alu.sv
`include "rv_core_defs.svh"

module rv_alu (
	input  rv_core_pkg::alu_op_t op,
	input  logic [`RV_XLEN-1:0] a,
	input  logic [`RV_XLEN-1:0] b,
	output logic [`RV_XLEN-1:0] y,
	output logic                eq // Branch compare
);
	import rv_core_pkg::*;

	logic slt;

	// Signed less-than for SLT
	assign slt = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR:  y = a | b;
			ALU_XOR: y = a ^ b;
			ALU_SLT: y = {{(`RV_XLEN-1){1'b0}}, slt};
			default: y = a + b; // Unused codes behave as add
		endcase
	end

	// Independent of op, so branches need no special ALU code
	assign eq = (a == b);

endmodule

//--- verilog/rv_decoder.sv
`include "rv_core_defs.svh"

module rv_decoder (
	input  logic [`RV_XLEN-1:0]  instr,
	output rv_core_pkg::decoded_t dec
);
	import rv_core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_s;
	logic [`RV_XLEN-1:0] imm_b;
	logic [`RV_XLEN-1:0] imm_u;
	logic [`RV_XLEN-1:0] imm_j;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// Immediate formats, all sign-extended from bit 31
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		// Defaults describe a halt that touches no register
		dec.op = OP_HALT;
		dec.alu_op = ALU_ADD;
		dec.rd = instr[11:7];
		dec.rs1 = instr[19:15];
		dec.rs2 = instr[24:20];
		dec.imm = imm_i;
		dec.ren = 2'b00;
		dec.wen = 1'b0;

		case (opcode)
			7'b0110111: begin // LUI
				dec.op = OP_LUI;
				dec.imm = imm_u;
				dec.wen = 1'b1;
			end
			7'b0010011: begin // OP-IMM, only ADDI
				if (funct3 == 3'b000) begin
					dec.op = OP_ADDI;
					dec.ren = 2'b01;
					dec.wen = 1'b1;
				end
			end
			7'b0110011: begin // OP
				dec.op = OP_ALU_R;
				dec.ren = 2'b11;
				dec.wen = 1'b1;
				case ({funct7, funct3})
					10'h000: dec.alu_op = ALU_ADD;
					10'h100: dec.alu_op = ALU_SUB;
					10'h007: dec.alu_op = ALU_AND;
					10'h006: dec.alu_op = ALU_OR;
					10'h004: dec.alu_op = ALU_XOR;
					10'h002: dec.alu_op = ALU_SLT;
					default: begin // Unsupported R-type falls back to halt
						dec.op = OP_HALT;
						dec.ren = 2'b00;
						dec.wen = 1'b0;
					end
				endcase
			end
			7'b0000011: begin // Word loads only
				if (funct3 == 3'b010) begin
					dec.op = OP_LW;
					dec.ren = 2'b01;
					dec.wen = 1'b1;
				end
			end
			7'b0100011: begin
				if (funct3 == 3'b010) begin
					dec.op = OP_SW;
					dec.imm = imm_s;
					dec.ren = 2'b11; // rs2 carries store data
				end
			end
			7'b1100011: begin
				dec.imm = imm_b;
				if (funct3 == 3'b000 || funct3 == 3'b001) begin
					dec.op = (funct3 == 3'b000) ? OP_BEQ : OP_BNE;
					dec.ren = 2'b11;
				end
			end
			7'b1101111: begin // JAL
				dec.op = OP_JAL;
				dec.imm = imm_j;
				dec.wen = 1'b1;
			end
			7'b1110011: dec.op = OP_HALT; // SYSTEM, EBREAK halts
			default: dec.op = OP_HALT;
		endcase
	end

endmodule

//--- verilog/rv_gpr.sv
`include "rv_core_defs.svh"

module rv_gpr (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [1:0]            ren, // rs2, rs1
	input  logic                  wen, // rd
	input  logic [`RV_REG_AW-1:0] raddr1,
	input  logic [`RV_REG_AW-1:0] raddr2,
	input  logic [`RV_REG_AW-1:0] waddr,
	input  logic [`RV_XLEN-1:0]   wdata,
	output logic [`RV_XLEN-1:0]   rdata1,
	output logic [`RV_XLEN-1:0]   rdata2
);

	logic [`RV_XLEN-1:0] regs [`RV_NREGS];

	// Whole file clears on reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen) begin
			regs[waddr] <= (waddr != '0) ? wdata : '0; // x0 stays zero
		end
	end

	// Disabled port reads zero
	assign rdata1 = ren[0] ? regs[raddr1] : '0;
	assign rdata2 = ren[1] ? regs[raddr2] : '0;

endmodule

//--- verilog/rv_core_pkg.sv
`include "rv_core_defs.svh"

package rv_core_pkg;

	// Instruction classes the decoder can produce
	typedef enum logic [3:0] {
		OP_LUI,
		OP_ADDI,
		OP_ALU_R, // Register-register arithmetic
		OP_LW,
		OP_SW,
		OP_BEQ,
		OP_BNE,
		OP_JAL,
		OP_HALT // EBREAK and every unknown encoding
	} instr_op_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT // Signed compare
	} alu_op_t;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_EXECUTE,
		ST_MEM,
		ST_WRITEBACK,
		ST_HALTED
	} ctrl_state_t;

	typedef struct packed {
		instr_op_t              op;
		alu_op_t                alu_op;
		logic [`RV_REG_AW-1:0]  rd;
		logic [`RV_REG_AW-1:0]  rs1;
		logic [`RV_REG_AW-1:0]  rs2;
		logic [`RV_XLEN-1:0]    imm; // Sign-extended already
		logic [1:0]             ren; // Bit 1 rs2, bit 0 rs1
		logic                   wen; // Writes rd
	} decoded_t;

	// Master side of one Wishbone classic request
	typedef struct packed {
		logic               cyc;
		logic               stb;
		logic               we;
		logic [`RV_XLEN-1:0] adr;
		logic [`RV_XLEN-1:0] dat_w;
	} wb_req_t;

endpackage

//--- verilog/rv_core_defs.svh
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Data path width in bits
`define RV_XLEN 32

// Register address width, 32 architectural registers
`define RV_REG_AW 5

// Address of the first instruction fetched after reset
`define RV_RESET_PC 32'h0000_0000

// Number of general purpose registers
`define RV_NREGS (1 << `RV_REG_AW)

// Shorthand for the instruction length in bytes
`define RV_ILEN_BYTES 4

`endif
